// File: riscv_top.f
+incdir+common
common/riscv_pkg.sv
riscv_core/riscv_hazardunit.sv
riscv_core/riscv_decoder.sv
riscv_core/riscv_regfile.sv
riscv_core/riscv_datapath.sv
verilog/riscv_mem.sv
verilog/riscv_top.sv
verification/riscv_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= riscv_tb
FLIST     ?= riscv_top.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FLIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf $(OBJDIR)

// File: verification/riscv_tb.sv
`timescale 1ns/1ps
`include "riscv_settings.svh"

module riscv_tb
   import riscv_pkg::*;
();

   localparam int RST_CYCLES = 10;
   localparam int BUDGET     = 60;  // store collection cycles per test
   localparam int NTESTS     = 6;
   // reset may stretch to a full imem load, x2 margin
   localparam int TIMEOUT_NS = NTESTS * (BUDGET + `RISCV_IMEM_DEPTH + RST_CYCLES) * 20 * 2;

   logic        clk;
   logic        rst_n;
   logic        imem_we;
   word_t       imem_addr;
   word_t       imem_wdata;
   logic        dmem_we;
   word_t       dmem_addr;
   word_t       dmem_wdata;
   word_t       prog[$];      // program image, word 0 at address 0
   word_t       exp_addr[$];
   word_t       exp_data[$];
   word_t       got_addr[$];
   word_t       got_data[$];
   logic [15:0] lfsr;
   int          errors;
   int          tests_run;
   int          tests_failed;

   riscv_top dut0 (
      .i_clk       (clk),
      .i_rst_n     (rst_n),
      .i_imem_we   (imem_we),
      .i_imem_addr (imem_addr),
      .i_imem_wdata(imem_wdata),
      .o_dmem_we   (dmem_we),
      .o_dmem_addr (dmem_addr),
      .o_dmem_wdata(dmem_wdata)
   );

   always #10 clk = ~clk;  // 20 ns period

   // rv32i encodings, straight from the isa field layout
   function automatic word_t op_rr(input logic [6:0] f7, input logic [2:0] f3,
                                   input int rd, input int rs1, input int rs2);
      return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], 7'b0110011};
   endfunction

   function automatic word_t addi(input int rd, input int rs1, input int imm);
      return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'b0010011};
   endfunction

   function automatic word_t lw(input int rd, input int rs1, input int imm);
      return {imm[11:0], rs1[4:0], 3'b010, rd[4:0], 7'b0000011};
   endfunction

   function automatic word_t sw(input int rs2, input int rs1, input int imm);
      return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
   endfunction

   function automatic word_t beq(input int rs1, input int rs2, input int off);
      return {off[12], off[10:5], rs2[4:0], rs1[4:0], 3'b000, off[4:1], off[11],
              7'b1100011};
   endfunction

   function automatic word_t jal(input int rd, input int off);
      return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'b1101111};
   endfunction

   function automatic word_t lui(input int rd, input word_t upper);
      return {upper[19:0], rd[4:0], 7'b0110111};
   endfunction

   // x^16 + x^14 + x^13 + x^11
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   function automatic word_t take_bits(input int n);
      word_t v;
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         lfsr = lfsr_next(lfsr); // one step per bit
         v    = {v[30:0], lfsr[0]};
      end
      return v;
   endfunction

   task automatic check_word(input string name, input word_t got, input word_t exp);
      if (got !== exp)
      begin
         errors++;
         $display("ERR %s got %08h expected %08h", name, got, exp);
      end
   endtask

   task automatic check_count(input string name, input int got, input int exp);
      if (got != exp)
      begin
         errors++;
         $display("ERR %s got %0h expected %0h", name, got, exp);
      end
   endtask

   task automatic begin_case;
      prog.delete();
      exp_addr.delete();
      exp_data.delete();
   endtask

   task automatic expect_store(input int addr, input word_t data);
      exp_addr.push_back(word_t'(addr));
      exp_data.push_back(data);
   endtask

   // load during reset, release, gather strobes, compare in order
   task automatic execute_case(input string name);
      int n;
      int ncmp;
      int errs_before;
      errs_before = errors;
      n = (prog.size() > RST_CYCLES) ? prog.size() : RST_CYCLES;
      @(posedge clk);
      #1;
      rst_n = 1'b0;
      for (int i = 0; i < n; i++)
      begin
         imem_we    = (i < prog.size());
         imem_addr  = word_t'(i * 4);
         imem_wdata = (i < prog.size()) ? prog[i] : '0;
         @(posedge clk);
         #1;
      end
      imem_we = 1'b0;
      rst_n   = 1'b1;
      got_addr.delete();
      got_data.delete();
      repeat (BUDGET)
      begin
         @(negedge clk);             // strobe settled mid cycle
         if (dmem_we)
         begin
            got_addr.push_back(dmem_addr);
            got_data.push_back(dmem_wdata);
         end
      end
      check_count("store count", got_addr.size(), exp_addr.size());
      ncmp = (got_addr.size() < exp_addr.size()) ? got_addr.size() : exp_addr.size();
      for (int i = 0; i < ncmp; i++)
      begin
         check_word($sformatf("o_dmem_addr[%0d]", i), got_addr[i], exp_addr[i]);
         check_word($sformatf("o_dmem_wdata[%0d]", i), got_data[i], exp_data[i]);
      end
      tests_run++;
      if (errors == errs_before)
         $display("test %-14s ok, %0d stores", name, got_addr.size());
      else
      begin
         tests_failed++;
         $display("test %-14s failed, %0d errors", name, errors - errs_before);
      end
   endtask

   // each result used at distance one and two
   task automatic alu_chain;
      int    a;
      int    b;
      word_t r3, r4, r5, r6, r7, r8, r9;
      a = 291;
      b = -1110;
      begin_case();
      prog.push_back(addi(1, 0, a));
      prog.push_back(addi(2, 0, b));
      prog.push_back(op_rr(7'h00, 3'h0, 3, 1, 2));  // add
      prog.push_back(op_rr(7'h20, 3'h0, 4, 3, 1));  // sub
      prog.push_back(op_rr(7'h00, 3'h7, 5, 4, 3));  // and
      prog.push_back(op_rr(7'h00, 3'h6, 6, 5, 4));  // or
      prog.push_back(op_rr(7'h00, 3'h4, 7, 6, 5));  // xor
      prog.push_back(op_rr(7'h00, 3'h2, 8, 6, 7));  // slt
      prog.push_back(addi(9, 8, 7));
      prog.push_back(sw(9, 0, 0));                  // data from memory stage
      prog.push_back(sw(8, 0, 4));
      for (int k = 3; k <= 7; k++)
         prog.push_back(sw(k, 0, 4 * k - 4));
      prog.push_back(jal(0, 0));
      r3 = a + b;
      r4 = r3 - word_t'(a);
      r5 = r4 & r3;
      r6 = r5 | r4;
      r7 = r6 ^ r5;
      r8 = ($signed(r6) < $signed(r7)) ? 32'd1 : 32'd0;
      r9 = r8 + 32'd7;
      expect_store(0, r9);
      expect_store(4, r8);
      expect_store(8, r3);
      expect_store(12, r4);
      expect_store(16, r5);
      expect_store(20, r6);
      expect_store(24, r7);
      execute_case("alu_chain");
   endtask

   task automatic lui_forward;
      begin_case();
      prog.push_back(lui(1, 32'h12345));
      prog.push_back(addi(2, 1, 32'h67));   // lui still in memory stage
      prog.push_back(sw(2, 0, 0));
      prog.push_back(sw(1, 0, 4));
      prog.push_back(lui(3, 32'hABCDE));
      prog.push_back(sw(3, 0, 8));          // store data from lui imm
      prog.push_back(jal(0, 0));
      expect_store(0, 32'h1234_5067);
      expect_store(4, 32'h1234_5000);
      expect_store(8, 32'hABCD_E000);
      execute_case("lui_forward");
   endtask

   task automatic load_use;
      begin_case();
      prog.push_back(addi(1, 0, 42));
      prog.push_back(sw(1, 0, 16));
      prog.push_back(lw(2, 0, 16));
      prog.push_back(op_rr(7'h00, 3'h0, 3, 2, 1)); // one bubble
      prog.push_back(sw(3, 0, 20));
      prog.push_back(lw(4, 0, 16));
      prog.push_back(sw(4, 0, 24));                // load feeds store data
      prog.push_back(jal(0, 0));
      expect_store(16, 32'd42);
      expect_store(20, 32'd84);
      expect_store(24, 32'd42);
      execute_case("load_use");
   endtask

   task automatic branch_flush;
      begin_case();
      prog.push_back(addi(1, 0, 5));   // 0
      prog.push_back(addi(2, 0, 5));   // 4
      prog.push_back(beq(1, 2, 12));   // 8, taken to 20
      prog.push_back(sw(1, 0, 0));     // 12 shadow
      prog.push_back(sw(2, 0, 4));     // 16 shadow
      prog.push_back(sw(1, 0, 8));     // 20
      prog.push_back(jal(5, 12));      // 24, link 28
      prog.push_back(sw(1, 0, 12));    // 28 shadow
      prog.push_back(sw(1, 0, 16));    // 32 shadow
      prog.push_back(sw(5, 0, 20));    // 36
      prog.push_back(addi(3, 0, 7));   // 40
      prog.push_back(beq(1, 3, 8));    // 44 not taken
      prog.push_back(sw(3, 0, 24));
      prog.push_back(sw(1, 0, 28));
      prog.push_back(jal(0, 0));
      expect_store(8, 32'd5);
      expect_store(20, 32'd28);
      expect_store(24, 32'd7);
      expect_store(28, 32'd5);
      execute_case("branch_flush");
   endtask

   task automatic zero_register;
      begin_case();
      prog.push_back(addi(0, 0, 85));       // dropped
      prog.push_back(sw(0, 0, 0));
      prog.push_back(addi(1, 0, 3));
      prog.push_back(sw(1, 0, 4));
      prog.push_back(lui(0, 32'h12345));    // dropped too
      prog.push_back(sw(0, 0, 8));
      prog.push_back(jal(0, 0));
      expect_store(0, 32'd0);
      expect_store(4, 32'd3);
      expect_store(8, 32'd0);
      execute_case("zero_register");
   endtask

   // lfsr constants via lui+addi, then an add/sub/xor chain
   task automatic random_chain;
      word_t c;
      word_t hi;
      word_t lo;
      word_t v [3];
      word_t s4, s5, s6, s7;
      begin_case();
      for (int k = 0; k < 3; k++)
      begin
         c    = take_bits(32);
         lo   = {{20{c[11]}}, c[11:0]};
         hi   = (c - lo) >> 12;    // rounds for the signed low part
         v[k] = (hi << 12) + lo;
         prog.push_back(lui(k + 1, hi));
         prog.push_back(addi(k + 1, k + 1, lo));
      end
      prog.push_back(op_rr(7'h00, 3'h0, 4, 1, 2));  // add
      prog.push_back(op_rr(7'h20, 3'h0, 5, 4, 3));  // sub
      prog.push_back(op_rr(7'h00, 3'h4, 6, 5, 1));  // xor
      prog.push_back(op_rr(7'h00, 3'h0, 7, 6, 6));
      for (int k = 7; k >= 1; k--)
         prog.push_back(sw(k, 0, 28 - 4 * k));
      prog.push_back(jal(0, 0));
      s4 = v[0] + v[1];
      s5 = s4 - v[2];
      s6 = s5 ^ v[0];
      s7 = s6 + s6;
      expect_store(0, s7);
      expect_store(4, s6);
      expect_store(8, s5);
      expect_store(12, s4);
      expect_store(16, v[2]);
      expect_store(20, v[1]);
      expect_store(24, v[0]);
      execute_case("random_chain");
   endtask

   initial
   begin
      #(TIMEOUT_NS);
      $display("watchdog expired, the tests did not finish in time");
      $display("*** FAILED ***");
      $finish;
   end

   initial
   begin
      clk          = 1'b0;
      rst_n        = 1'b0;
      imem_we      = 1'b0;
      imem_addr    = '0;
      imem_wdata   = '0;
      errors       = 0;
      tests_run    = 0;
      tests_failed = 0;
      lfsr         = 16'd33864;
      alu_chain();
      lui_forward();
      load_use();
      branch_flush();
      zero_register();
      random_chain();
      $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
      if (errors == 0 && tests_failed == 0)
         $display("*** PASSED ***");
      else
         $display("*** FAILED ***");
      $finish;
   end

endmodule

// File: verilog/riscv_top.sv
`timescale 1ns/1ps
`include "riscv_settings.svh"

module riscv_top
   import riscv_pkg::*;
(
   input  logic  i_clk,
   input  logic  i_rst_n,
   input  logic  i_imem_we,     // program load, while in reset
   input  word_t i_imem_addr,
   input  word_t i_imem_wdata,
   output logic  o_dmem_we,     // one strobe per sw
   output word_t o_dmem_addr,
   output word_t o_dmem_wdata
);

   word_t imem_addr;
   word_t imem_rdata;
   word_t dmem_rdata;

   riscv_datapath dp0 (
      .i_clk       (i_clk),
      .i_rst_n     (i_rst_n),
      .o_imem_addr (imem_addr),
      .i_imem_rdata(imem_rdata),
      .o_dmem_we   (o_dmem_we),
      .o_dmem_addr (o_dmem_addr),
      .o_dmem_wdata(o_dmem_wdata),
      .i_dmem_rdata(dmem_rdata)
   );

   // instruction side, written only from outside
   riscv_mem #(.DEPTH(`RISCV_IMEM_DEPTH)) imem0 (
      .i_clk  (i_clk),
      .i_we   (i_imem_we),
      .i_waddr(i_imem_addr),
      .i_wdata(i_imem_wdata),
      .i_raddr(imem_addr),
      .o_rdata(imem_rdata)
   );

   // data side, same address for lw and sw
   riscv_mem #(.DEPTH(`RISCV_DMEM_DEPTH)) dmem0 (
      .i_clk  (i_clk),
      .i_we   (o_dmem_we),
      .i_waddr(o_dmem_addr),
      .i_wdata(o_dmem_wdata),
      .i_raddr(o_dmem_addr),
      .o_rdata(dmem_rdata)
   );

endmodule

// File: verilog/riscv_mem.sv
`timescale 1ns/1ps

module riscv_mem
   import riscv_pkg::*;
#(
   parameter int DEPTH = 64   // words
)
(
   input  logic  i_clk,
   input  logic  i_we,
   input  word_t i_waddr,     // byte address
   input  word_t i_wdata,
   input  word_t i_raddr,     // byte address
   output word_t o_rdata
);

   localparam int AW = $clog2(DEPTH);

   word_t mem [DEPTH];

   // word index from bit 2 upward
   always_ff @(posedge i_clk)
   begin
      if (i_we)
         mem[i_waddr[AW+1:2]] <= i_wdata;
   end

   assign o_rdata = mem[i_raddr[AW+1:2]]; // async read

endmodule

// File: riscv_core/riscv_datapath.sv
`timescale 1ns/1ps

module riscv_datapath
   import riscv_pkg::*;
(
   input  logic  i_clk,
   input  logic  i_rst_n,
   output word_t o_imem_addr,
   input  word_t i_imem_rdata,
   output logic  o_dmem_we,
   output word_t o_dmem_addr,
   output word_t o_dmem_wdata,
   input  word_t i_dmem_rdata
);

   word_t pc_f;
   // fetch/decode
   word_t instr_d, pc_d, rs1data_d, rs2data_d, imm_d;
   logic  valid_d;
   regaddr_t rs1addr_d, rs2addr_d, rdaddr_d;
   logic  regw_d, memw_d, branch_d, jump_d, alusrc_d;
   result_src_t resultsrc_d;
   alu_op_t aluop_d;
   // decode/execute
   logic  valid_e, regw_e, memw_e, branch_e, jump_e, alusrc_e;
   result_src_t resultsrc_e;
   alu_op_t aluop_e;
   word_t rs1data_e, rs2data_e, imm_e, pc_e;
   regaddr_t rs1addr_e, rs2addr_e, rdaddr_e;
   word_t srca_e, srcb_fwd_e, srcb_e, alu_e;
   logic  pcsrc_e;
   // execute/memory and memory/writeback
   logic  valid_m, regw_m, memw_m;
   result_src_t resultsrc_m, resultsrc_w;
   word_t alu_m, wdata_m, imm_m, pc_m;
   regaddr_t rdaddr_m, rdaddr_w;
   logic  valid_w, regw_w;
   word_t alu_w, rdata_w, imm_w, pc_w, result_w;
   // hazard control
   fwd_sel_t fwda, fwdb;
   logic  stallpc, stallfd, flushfd, flushde;

   function automatic word_t fwd_mux(input fwd_sel_t sel, input word_t rf,
                                     input word_t wb, input word_t am, input word_t im);
      case (sel)
         FWD_WB:    return wb;
         FWD_ALU_M: return am;
         FWD_IMM_M: return im;
         default:   return rf;
      endcase
   endfunction

   // fetch, redirect beats the load-use stall
   always_ff @(posedge i_clk or negedge i_rst_n)
   begin
      if (!i_rst_n)
         pc_f <= '0;
      else if (pcsrc_e)
         pc_f <= pc_e + imm_e;       // beq and jal share the target adder
      else if (!stallpc)
         pc_f <= pc_f + word_t'(4);
   end
   assign o_imem_addr = pc_f;

   always_ff @(posedge i_clk or negedge i_rst_n)
   begin
      if (!i_rst_n)
         valid_d <= 1'b0;
      else if (flushfd)
         valid_d <= 1'b0;            // wrong-path fetch
      else if (!stallfd)
         valid_d <= 1'b1;
   end

   always_ff @(posedge i_clk)
   begin
      if (!stallfd)
      begin
         instr_d <= i_imem_rdata;
         pc_d    <= pc_f;
      end
   end

   riscv_decoder dec0 (
      .i_instr(instr_d), .o_rs1addr(rs1addr_d), .o_rs2addr(rs2addr_d),
      .o_rdaddr(rdaddr_d), .o_regw(regw_d), .o_memw(memw_d), .o_branch(branch_d),
      .o_jump(jump_d), .o_alusrc_imm(alusrc_d), .o_resultsrc(resultsrc_d),
      .o_aluop(aluop_d), .o_imm(imm_d)
   );

   riscv_regfile rf0 (
      .i_clk(i_clk), .i_rst_n(i_rst_n), .i_rs1addr(rs1addr_d), .i_rs2addr(rs2addr_d),
      .i_rdaddr(rdaddr_w), .i_we(regw_w && valid_w), .i_wdata(result_w),
      .o_rs1data(rs1data_d), .o_rs2data(rs2data_d)
   );

   // decode/execute controls, cleared for every bubble
   always_ff @(posedge i_clk or negedge i_rst_n)
   begin
      if (!i_rst_n || flushde || !valid_d)
      begin
         valid_e     <= 1'b0;
         regw_e      <= 1'b0;
         memw_e      <= 1'b0;
         branch_e    <= 1'b0;
         jump_e      <= 1'b0;
         resultsrc_e <= RS_ALU; // no stale load seen by the hazard unit
      end
      else
      begin
         valid_e     <= 1'b1;
         regw_e      <= regw_d;
         memw_e      <= memw_d;
         branch_e    <= branch_d;
         jump_e      <= jump_d;
         resultsrc_e <= resultsrc_d;
      end
   end

   always_ff @(posedge i_clk)
   begin
      alusrc_e  <= alusrc_d;
      aluop_e   <= aluop_d;
      rs1data_e <= rs1data_d;
      rs2data_e <= rs2data_d;
      rs1addr_e <= rs1addr_d;
      rs2addr_e <= rs2addr_d;
      rdaddr_e  <= rdaddr_d;
      imm_e     <= imm_d;
      pc_e      <= pc_d;
   end

   // execute
   assign srca_e     = fwd_mux(fwda, rs1data_e, result_w, alu_m, imm_m);
   assign srcb_fwd_e = fwd_mux(fwdb, rs2data_e, result_w, alu_m, imm_m);
   assign srcb_e     = alusrc_e ? imm_e : srcb_fwd_e;

   always_comb
   begin
      case (aluop_e)
         ALU_SUB: alu_e = srca_e - srcb_e;
         ALU_AND: alu_e = srca_e & srcb_e;
         ALU_OR:  alu_e = srca_e | srcb_e;
         ALU_XOR: alu_e = srca_e ^ srcb_e;
         ALU_SLT: alu_e = word_t'($signed(srca_e) < $signed(srcb_e));
         default: alu_e = srca_e + srcb_e;
      endcase
   end

   // beq compares the forwarded register values, not the alu output
   assign pcsrc_e = valid_e && (jump_e || (branch_e && (srca_e == srcb_fwd_e)));

   always_ff @(posedge i_clk or negedge i_rst_n)
   begin
      if (!i_rst_n)
      begin
         valid_m     <= 1'b0;
         regw_m      <= 1'b0;
         memw_m      <= 1'b0;
         resultsrc_m <= RS_ALU;
         valid_w     <= 1'b0;
         regw_w      <= 1'b0;
         resultsrc_w <= RS_ALU;
      end
      else
      begin
         valid_m     <= valid_e;
         regw_m      <= regw_e;
         memw_m      <= memw_e;
         resultsrc_m <= resultsrc_e;
         valid_w     <= valid_m;
         regw_w      <= regw_m;
         resultsrc_w <= resultsrc_m;
      end
   end

   always_ff @(posedge i_clk)
   begin
      alu_m    <= alu_e;
      wdata_m  <= srcb_fwd_e;        // sw data
      imm_m    <= imm_e;
      pc_m     <= pc_e;
      rdaddr_m <= rdaddr_e;
      alu_w    <= alu_m;
      rdata_w  <= i_dmem_rdata;
      imm_w    <= imm_m;
      pc_w     <= pc_m;
      rdaddr_w <= rdaddr_m;
   end

   // memory stage drives the data memory and the store strobe
   assign o_dmem_we    = valid_m && memw_m;
   assign o_dmem_addr  = alu_m;
   assign o_dmem_wdata = wdata_m;

   always_comb
   begin
      case (resultsrc_w)
         RS_MEM:  result_w = rdata_w;
         RS_PC4:  result_w = pc_w + word_t'(4);
         RS_IMM:  result_w = imm_w;
         default: result_w = alu_w;
      endcase
   end

   riscv_hazardunit hzu0 (
      .i_rs1addr_d(rs1addr_d), .i_rs2addr_d(rs2addr_d), .i_rs1addr_e(rs1addr_e),
      .i_rs2addr_e(rs2addr_e), .i_rdaddr_e(rdaddr_e), .i_rdaddr_m(rdaddr_m),
      .i_rdaddr_w(rdaddr_w), .i_regw_m(regw_m), .i_regw_w(regw_w),
      .i_resultsrc_e(resultsrc_e), .i_resultsrc_m(resultsrc_m), .i_pcsrc(pcsrc_e),
      .o_fwda(fwda), .o_fwdb(fwdb), .o_stallpc(stallpc), .o_stallfd(stallfd),
      .o_flushfd(flushfd), .o_flushde(flushde)
   );

endmodule

// File: riscv_core/riscv_regfile.sv
`timescale 1ns/1ps

module riscv_regfile
   import riscv_pkg::*;
(
   input  logic     i_clk,
   input  logic     i_rst_n,
   input  regaddr_t i_rs1addr,
   input  regaddr_t i_rs2addr,
   input  regaddr_t i_rdaddr,
   input  logic     i_we,
   input  word_t    i_wdata,
   output word_t    o_rs1data,
   output word_t    o_rs2data
);

   word_t regs [32];

   always_ff @(posedge i_clk or negedge i_rst_n)
   begin
      if (!i_rst_n)
      begin
         for (int i = 0; i < 32; i++)
            regs[i] <= '0;
      end
      else if (i_we && (i_rdaddr != '0)) // x0 stays zero
         regs[i_rdaddr] <= i_wdata;
   end

   // write-through so decode sees the writeback of the same cycle
   assign o_rs1data = (i_rs1addr == '0) ? '0 :
                      (i_we && (i_rs1addr == i_rdaddr)) ? i_wdata : regs[i_rs1addr];
   assign o_rs2data = (i_rs2addr == '0) ? '0 :
                      (i_we && (i_rs2addr == i_rdaddr)) ? i_wdata : regs[i_rs2addr];

endmodule

// File: riscv_core/riscv_decoder.sv
`timescale 1ns/1ps

module riscv_decoder
   import riscv_pkg::*;
(
   input  word_t       i_instr,
   output regaddr_t    o_rs1addr,
   output regaddr_t    o_rs2addr,
   output regaddr_t    o_rdaddr,
   output logic        o_regw,
   output logic        o_memw,
   output logic        o_branch,
   output logic        o_jump,
   output logic        o_alusrc_imm,
   output result_src_t o_resultsrc,
   output alu_op_t     o_aluop,
   output word_t       o_imm
);

   opcode_t    opcode;
   logic [2:0] funct3;
   logic       funct7b5; // sub vs add
   word_t      imm_i;
   word_t      imm_s;
   word_t      imm_b;
   word_t      imm_j;
   word_t      imm_u;

   assign opcode   = opcode_t'(i_instr[6:0]);
   assign funct3   = i_instr[14:12];
   assign funct7b5 = i_instr[30];

   assign imm_i = {{20{i_instr[31]}}, i_instr[31:20]};
   assign imm_s = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
   assign imm_b = {{19{i_instr[31]}}, i_instr[31], i_instr[7], i_instr[30:25],
                   i_instr[11:8], 1'b0};
   assign imm_j = {{11{i_instr[31]}}, i_instr[31], i_instr[19:12], i_instr[20],
                   i_instr[30:21], 1'b0};
   assign imm_u = {i_instr[31:12], 12'b0};

   assign o_rdaddr = i_instr[11:7];

   always_comb
   begin
      // anything unrecognised falls out as a bubble
      o_rs1addr    = '0;
      o_rs2addr    = '0;
      o_regw       = 1'b0;
      o_memw       = 1'b0;
      o_branch     = 1'b0;
      o_jump       = 1'b0;
      o_alusrc_imm = 1'b0;
      o_resultsrc  = RS_ALU;
      o_aluop      = ALU_ADD;
      o_imm        = imm_i;
      case (opcode)
         OPC_OP:
         begin
            o_rs1addr = i_instr[19:15];
            o_rs2addr = i_instr[24:20];
            o_regw    = 1'b1;
            case (funct3)
               3'b000:  o_aluop = funct7b5 ? ALU_SUB : ALU_ADD;
               3'b010:  o_aluop = ALU_SLT;
               3'b100:  o_aluop = ALU_XOR;
               3'b110:  o_aluop = ALU_OR;
               3'b111:  o_aluop = ALU_AND;
               default: o_regw  = 1'b0;   // shifts etc not supported
            endcase
         end
         OPC_OP_IMM:
         begin
            if (funct3 == 3'b000)          // addi only
            begin
               o_rs1addr    = i_instr[19:15];
               o_regw       = 1'b1;
               o_alusrc_imm = 1'b1;
            end
         end
         OPC_LOAD:
         begin
            if (funct3 == 3'b010)          // word loads only
            begin
               o_rs1addr    = i_instr[19:15];
               o_regw       = 1'b1;
               o_alusrc_imm = 1'b1;
               o_resultsrc  = RS_MEM;
            end
         end
         OPC_STORE:
         begin
            if (funct3 == 3'b010)
            begin
               o_rs1addr    = i_instr[19:15];
               o_rs2addr    = i_instr[24:20]; // store data
               o_memw       = 1'b1;
               o_alusrc_imm = 1'b1;
               o_imm        = imm_s;
            end
         end
         OPC_BRANCH:
         begin
            if (funct3 == 3'b000)          // beq
            begin
               o_rs1addr = i_instr[19:15];
               o_rs2addr = i_instr[24:20];
               o_branch  = 1'b1;
               o_imm     = imm_b;
            end
         end
         OPC_JAL:
         begin
            o_jump      = 1'b1;
            o_regw      = 1'b1;
            o_resultsrc = RS_PC4; // link value
            o_imm       = imm_j;
         end
         OPC_LUI:
         begin
            o_regw      = 1'b1;
            o_resultsrc = RS_IMM;
            o_imm       = imm_u;
         end
         default: ;
      endcase
   end

endmodule

// File: riscv_core/riscv_hazardunit.sv
`timescale 1ns/1ps

module riscv_hazardunit
   import riscv_pkg::*;
(
   input  regaddr_t    i_rs1addr_d,
   input  regaddr_t    i_rs2addr_d,
   input  regaddr_t    i_rs1addr_e,
   input  regaddr_t    i_rs2addr_e,
   input  regaddr_t    i_rdaddr_e,
   input  regaddr_t    i_rdaddr_m,
   input  regaddr_t    i_rdaddr_w,
   input  logic        i_regw_m,
   input  logic        i_regw_w,
   input  result_src_t i_resultsrc_e,
   input  result_src_t i_resultsrc_m,
   input  logic        i_pcsrc,     // taken beq or jal in execute
   output fwd_sel_t    o_fwda,
   output fwd_sel_t    o_fwdb,
   output logic        o_stallpc,
   output logic        o_stallfd,
   output logic        o_flushfd,
   output logic        o_flushde
);

   logic m_ok;     // memory stage writes a real register
   logic w_ok;     // same for writeback
   logic lui_m;    // memory stage result is the u-immediate
   logic load_use;

   // priority pick, youngest producer wins
   function automatic fwd_sel_t fwd_pick(input regaddr_t rs, input logic mok,
                                         input logic lui, input logic wok,
                                         input regaddr_t rdm, input regaddr_t rdw);
      fwd_sel_t sel;
      if (mok && (rdm == rs))
         sel = lui ? FWD_IMM_M : FWD_ALU_M;
      else if (wok && (rdw == rs))
         sel = FWD_WB;
      else
         sel = FWD_RF;
      return sel;
   endfunction

   assign m_ok  = i_regw_m && (i_rdaddr_m != '0);
   assign w_ok  = i_regw_w && (i_rdaddr_w != '0);
   assign lui_m = (i_resultsrc_m == RS_IMM);

   always_comb
   begin
      o_fwda = fwd_pick(i_rs1addr_e, m_ok, lui_m, w_ok, i_rdaddr_m, i_rdaddr_w);
      o_fwdb = fwd_pick(i_rs2addr_e, m_ok, lui_m, w_ok, i_rdaddr_m, i_rdaddr_w);
   end

   // lw in execute feeding the instruction in decode
   assign load_use = (i_resultsrc_e == RS_MEM) && (i_rdaddr_e != '0) &&
                     ((i_rs1addr_d == i_rdaddr_e) || (i_rs2addr_d == i_rdaddr_e));

   assign o_stallpc = load_use;
   assign o_stallfd = load_use;
   assign o_flushde = load_use || i_pcsrc; // bubble or wrong-path kill
   assign o_flushfd = i_pcsrc;

endmodule

// File: common/riscv_pkg.sv
package riscv_pkg;

`include "riscv_settings.svh"

   typedef logic [`RISCV_XLEN-1:0] word_t;   // data or instruction word
   typedef logic [4:0]             regaddr_t; // x0..x31

   // opcode groups the decoder knows about
   typedef enum logic [6:0] {
      OPC_OP     = 7'b0110011, // add sub and or xor slt
      OPC_OP_IMM = 7'b0010011, // addi
      OPC_LOAD   = 7'b0000011, // lw
      OPC_STORE  = 7'b0100011, // sw
      OPC_BRANCH = 7'b1100011, // beq
      OPC_JAL    = 7'b1101111,
      OPC_LUI    = 7'b0110111
   } opcode_t;

   // execute operand source
   typedef enum logic [1:0] {
      FWD_RF    = 2'd0, // value read in decode
      FWD_WB    = 2'd1, // writeback result
      FWD_ALU_M = 2'd2, // alu result in memory stage
      FWD_IMM_M = 2'd3  // lui immediate in memory stage
   } fwd_sel_t;

   // writeback source, RS_MEM also marks a load for the hazard unit
   typedef enum logic [1:0] {
      RS_ALU = 2'd0,
      RS_MEM = 2'd1,
      RS_PC4 = 2'd2,
      RS_IMM = 2'd3
   } result_src_t;

   typedef enum logic [2:0] {
      ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT
   } alu_op_t;

endpackage

// File: common/riscv_settings.svh
`ifndef RISCV_SETTINGS_SVH
`define RISCV_SETTINGS_SVH

// word width of the core
`define RISCV_XLEN 32

// memory sizes, counted in words
`define RISCV_IMEM_DEPTH 64
`define RISCV_DMEM_DEPTH 64

`endif
